// File: flist.f
+incdir+source
source/bubblePkg.sv
source/timingGenerator.sv
source/spiLoader.sv
source/bubbleLane.sv
source/ledDriver.sv
source/bubbleDriveTop.sv
verification/flashModel.sv
verification/tbBubbleDrive.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f flist.f --top-module tbBubbleDrive

./obj_dir/VtbBubbleDrive > sim.log
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0

// File: verification/tbBubbleDrive.sv
`include "bubble_params.svh"

module tbBubbleDrive;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int pageBytes = `LANE_COUNT * `PAGE_BITS / 8;
    localparam int startLimit = 50;
    localparam int accessLimit = 4000;
    // abcdefg, active high
    localparam logic [6:0] segTable [16] = '{
        7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33, 7'h5B, 7'h5F, 7'h70,
        7'h7F, 7'h7B, 7'h77, 7'h1F, 7'h4E, 7'h3D, 7'h4F, 7'h47
    };

    logic               MCLK = 1'b0;
    logic               rstN;
    logic               nBSEN;
    logic [`IMG_W-1:0]  imgNum;
    logic               clkOut;
    logic               dout0;
    logic               dout1;
    logic               bitStrobe;
    logic               nRomCs;
    logic               romMosi;
    logic               romMiso;
    logic               romClk;
    logic               nAccLed;
    logic               nWaitLed;
    logic               nReadLed;
    logic [7:0]         nFnd;
    logic [2:0]         nAnode;

    int    errs [1:6];
    int    timeouts;
    int    dataTest;
    int    expImg;
    int    expPage;
    int    strobeCount;
    int    edgesDriven;
    int    accessesStarted;
    logic  prevAccLed;

    always #10 MCLK = ~MCLK;

    bubbleDriveTop u_dut (
        .MCLK      (MCLK),
        .rstN      (rstN),
        .nBSEN     (nBSEN),
        .imgNum    (imgNum),
        .clkOut    (clkOut),
        .dout0     (dout0),
        .dout1     (dout1),
        .bitStrobe (bitStrobe),
        .nRomCs    (nRomCs),
        .romMosi   (romMosi),
        .romMiso   (romMiso),
        .romClk    (romClk),
        .nAccLed   (nAccLed),
        .nWaitLed  (nWaitLed),
        .nReadLed  (nReadLed),
        .nFnd      (nFnd),
        .nAnode    (nAnode)
    );

    flashModel flash0 (
        .nCs  (nRomCs),
        .sck  (romClk),
        .mosi (romMosi),
        .miso (romMiso)
    );

    // Page bit k, MSB first across the page bytes of one image
    function automatic logic pageBit(input int img, input int page, input int k);
        int addr;
        logic [7:0] data;
        addr = img * `PAGE_COUNT * pageBytes + page * pageBytes + k / 8;
        data = 8'((addr % 256) * 37 + 11);
        return data[7 - k % 8];
    endfunction

    function automatic logic [7:0] expectedFnd(input logic [2:0] anode, input int page);
        logic [3:0] nib;
        case (anode)
            3'b110: nib = 4'(page);
            3'b101: nib = 4'(page >> 4);
            default: nib = 4'(page >> 8);
        endcase
        return ~{segTable[nib], 1'b0};
    endfunction

    function automatic void flagMismatch(input int test, input string msg);
        errs[test] = errs[test] + 1;
        $display("[FAIL] time %0d ns: %s", $time, msg);
    endfunction

    function automatic void flagTimeout(input string what);
        timeouts = timeouts + 1;
        $display("Timeout at %0d ns: %s", $time, what);
    endfunction

    // Strobes per access, and accesses seen starting
    always @(posedge MCLK) begin
        prevAccLed <= nAccLed;
        if (!rstN || nAccLed) begin
            strobeCount <= 0;
        end else if (bitStrobe) begin
            strobeCount <= strobeCount + 1;
        end
        if (rstN && prevAccLed && !nAccLed) begin
            accessesStarted <= accessesStarted + 1;
        end
    end

    assert property (@(posedge MCLK) $rose(rstN) |-> nRomCs && !dout0 && !dout1
        && !bitStrobe && !clkOut && nAccLed && nWaitLed && nReadLed
        && nFnd == 8'hFF && nAnode == 3'b111)
        else flagMismatch(1, "outputs not at their reset values");

    assert property (@(posedge MCLK) disable iff (!rstN) bitStrobe |->
        dout0 == pageBit(expImg, expPage, 2 * strobeCount)
        && dout1 == pageBit(expImg, expPage, 2 * strobeCount + 1))
        else flagMismatch(dataTest, "lane data differs from the flash page");

    assert property (@(posedge MCLK) disable iff (!rstN)
        $rose(nAccLed) |-> strobeCount == `PAGE_BITS)
        else flagMismatch(dataTest, "wrong number of strobes in the access");

    // An access needs its own falling edge of nBSEN
    assert property (@(posedge MCLK) disable iff (!rstN)
        $fell(nAccLed) |-> accessesStarted + 1 == edgesDriven)
        else flagMismatch(4, "access started without a fresh nBSEN falling edge");

    assert property (@(posedge MCLK) disable iff (!rstN) $fell(nAccLed) |-> !nWaitLed)
        else flagMismatch(5, "wait LED off at access start");
    assert property (@(posedge MCLK) disable iff (!rstN)
        !nWaitLed |-> !nAccLed && strobeCount == 0 && !bitStrobe)
        else flagMismatch(5, "wait LED on outside the load phase");
    assert property (@(posedge MCLK) disable iff (!rstN)
        bitStrobe |-> !nReadLed && !nAccLed)
        else flagMismatch(5, "read or access LED off during a strobe");
    assert property (@(posedge MCLK) disable iff (!rstN)
        $rose(nAccLed) |-> nWaitLed && nReadLed)
        else flagMismatch(5, "LED still on after the access");

    assert property (@(posedge MCLK) disable iff (!rstN)
        (nAccLed && $past(nAccLed) && $past(nAccLed, 2) && nAnode != 3'b111)
        |-> nFnd == expectedFnd(nAnode, expPage))
        else flagMismatch(6, "segment code differs from the page nibble");

    task automatic idleGap();
        repeat (20 + $urandom % 200) @(negedge MCLK);
    endtask

    // Called on a falling edge while the DUT is idle
    task automatic runAccess(input int img, input bit holdLow);
        int cycles;
        imgNum = img[`IMG_W-1:0];
        expImg = img;
        @(negedge MCLK);
        nBSEN = 1'b0;
        edgesDriven = edgesDriven + 1;
        cycles = 0;
        while (nAccLed && cycles < startLimit) begin
            @(negedge MCLK);
            cycles++;
        end
        if (nAccLed) begin
            flagTimeout("access did not start after the nBSEN falling edge");
            nBSEN = 1'b1;
            return;
        end
        if (!holdLow) begin
            nBSEN = 1'b1;
        end
        cycles = 0;
        while (!nAccLed && cycles < accessLimit) begin
            @(negedge MCLK);
            cycles++;
        end
        if (!nAccLed) begin
            flagTimeout("access did not finish");
        end else begin
            expPage = (expPage + 1) % `PAGE_COUNT;
        end
    endtask

    initial begin
        int total;
        void'($urandom(20));
        rstN = 1'b0;
        nBSEN = 1'b1;
        imgNum = '0;
        dataTest = 2;
        repeat (10) @(negedge MCLK);
        rstN = 1'b1;
        repeat (5) @(negedge MCLK);
        $display("Test 1 reset values: %0d errors", errs[1]);

        runAccess(int'($urandom % 8), 1'b0);
        $display("Test 2 first access, page 0: %0d errors", errs[2]);

        dataTest = 3;
        repeat (4) begin
            idleGap();
            runAccess(int'($urandom % 8), 1'b0);
        end
        $display("Test 3 pages 1 to 3 and wrap: %0d errors", errs[3]);

        // Held low through the access, then a second edge
        dataTest = 4;
        idleGap();
        runAccess(int'($urandom % 8), 1'b1);
        repeat (200) @(negedge MCLK);
        nBSEN = 1'b1;
        repeat (10) @(negedge MCLK);
        runAccess(int'($urandom % 8), 1'b0);
        $display("Test 4 held nBSEN: %0d errors", errs[4]);

        // Long idle so every digit is scanned
        repeat (400) @(negedge MCLK);
        $display("Test 5 access LEDs: %0d errors", errs[5]);
        $display("Test 6 page display: %0d errors", errs[6]);

        total = errs[1] + errs[2] + errs[3] + errs[4] + errs[5] + errs[6];
        $display("Summary: 6 tests, %0d failed checks, %0d timeouts", total, timeouts);
        if (total == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: verification/flashModel.sv
module flashModel (
    input  logic  nCs,
    input  logic  sck,
    input  logic  mosi,
    output logic  miso
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0]  header;
    logic [7:0]   outByte;
    int unsigned  inBits = 0;
    int unsigned  outBits = 0;

    // Contents are a fixed rule of the byte address
    function automatic logic [7:0] byteAt(input logic [23:0] addr);
        return 8'(addr[7:0] * 8'd37 + 8'd11);
    endfunction

    // Command and address come in on rising edges
    always @(negedge nCs or posedge sck) begin
        if (!sck) begin
            // Falling chip select starts a new frame
            inBits = 0;
            header = '0;
        end else if (!nCs && inBits < 32) begin
            header = {header[30:0], mosi};
            inBits = inBits + 1;
        end
    end

    // Mode 0 read data goes out on falling edges, MSB first
    always @(negedge sck or posedge nCs) begin
        if (nCs) begin
            miso = 1'b0;
            outBits = 0;
        end else if (inBits == 32 && header[31:24] == 8'h03) begin
            outByte = byteAt(header[23:0] + 24'(outBits / 8));
            miso = outByte[7 - outBits % 8];
            outBits = outBits + 1;
        end
    end

endmodule

// File: source/bubbleDriveTop.sv
`include "bubble_params.svh"

module bubbleDriveTop (
    input  logic                MCLK,
    input  logic                rstN,
    input  logic                nBSEN,
    input  logic [`IMG_W-1:0]   imgNum,
    output logic                clkOut,
    output logic                dout0,
    output logic                dout1,
    output logic                bitStrobe,
    output logic                nRomCs,
    output logic                romMosi,
    input  logic                romMiso,
    output logic                romClk,
    output logic                nAccLed,
    output logic                nWaitLed,
    output logic                nReadLed,
    output logic [7:0]          nFnd,
    output logic [2:0]          nAnode
);
    import bubblePkg::*;

    accType_t                accType;
    loadReq_t                loadReq;
    bufWrite_t               bufWr;
    logic                    loadDone;
    logic                    bitOutEn;
    logic [`PAGE_W-1:0]      currPage;
    logic [`LANE_COUNT-1:0]  laneDout;

    timingGenerator timingGenerator0 (
        .MCLK     (MCLK),
        .rstN     (rstN),
        .nBSEN    (nBSEN),
        .imgNum   (imgNum),
        .loadDone (loadDone),
        .accType  (accType),
        .loadReq  (loadReq),
        .bitOutEn (bitOutEn),
        .currPage (currPage),
        .clkOut   (clkOut)
    );

    spiLoader spiLoader0 (
        .MCLK     (MCLK),
        .rstN     (rstN),
        .loadReq  (loadReq),
        .loadDone (loadDone),
        .bufWr    (bufWr),
        .nCs      (nRomCs),
        .mosi     (romMosi),
        .miso     (romMiso),
        .romClk   (romClk)
    );

    // Identical lanes, each picks its own bits off the shared write bus
    for (genvar i = 0; i < `LANE_COUNT; i++) begin : laneGen
        bubbleLane #(
            .LANE_ID (i)
        ) lane (
            .MCLK     (MCLK),
            .rstN     (rstN),
            .bufWr    (bufWr),
            .bitOutEn (bitOutEn),
            .accType  (accType),
            .dout     (laneDout[i])
        );
    end

    assign dout0 = laneDout[0];
    assign dout1 = laneDout[1];

    // Strobe lands in the first cycle the new data bit is on the pins
    always_ff @(posedge MCLK) begin
        if (!rstN) begin
            bitStrobe <= 1'b0;
        end else begin
            bitStrobe <= bitOutEn;
        end
    end

    ledDriver ledDriver0 (
        .MCLK     (MCLK),
        .rstN     (rstN),
        .accType  (accType),
        .currPage (currPage),
        .nAccLed  (nAccLed),
        .nWaitLed (nWaitLed),
        .nReadLed (nReadLed),
        .nFnd     (nFnd),
        .nAnode   (nAnode)
    );

endmodule

// File: source/ledDriver.sv
`include "bubble_params.svh"

module ledDriver (
    input  logic                  MCLK,
    input  logic                  rstN,
    input  bubblePkg::accType_t   accType,
    input  logic [`PAGE_W-1:0]    currPage,
    output logic                  nAccLed,
    output logic                  nWaitLed,
    output logic                  nReadLed,
    output logic [7:0]            nFnd,
    output logic [2:0]            nAnode
);
    import bubblePkg::*;

    localparam int scanW = $clog2(`SCAN_DIV);

    logic [scanW-1:0]  scanCnt;
    logic [1:0]        digitSel;
    logic [3:0]        nibble;
    logic [6:0]        segments;

    assign nAccLed  = (accType == ACC_IDLE);
    assign nWaitLed = (accType != ACC_LOAD);
    assign nReadLed = (accType != ACC_SHIFT);

    // Anode 0 shows the low nibble
    assign nibble = currPage[{digitSel, 2'b00} +: 4];

    // abcdefg, active high before inversion
    always_comb begin
        case (nibble)
            4'h0: segments = 7'b1111110;
            4'h1: segments = 7'b0110000;
            4'h2: segments = 7'b1101101;
            4'h3: segments = 7'b1111001;
            4'h4: segments = 7'b0110011;
            4'h5: segments = 7'b1011011;
            4'h6: segments = 7'b1011111;
            4'h7: segments = 7'b1110000;
            4'h8: segments = 7'b1111111;
            4'h9: segments = 7'b1111011;
            4'hA: segments = 7'b1110111;
            4'hB: segments = 7'b0011111;
            4'hC: segments = 7'b1001110;
            4'hD: segments = 7'b0111101;
            4'hE: segments = 7'b1001111;
            default: segments = 7'b1000111;
        endcase
    end

    always_ff @(posedge MCLK) begin
        if (!rstN) begin
            scanCnt  <= '0;
            digitSel <= 2'd0;
            nAnode   <= 3'b111;
            nFnd     <= 8'hFF;
        end else begin
            nAnode <= ~(3'b001 << digitSel);
            // dp stays dark
            nFnd   <= ~{segments, 1'b0};
            if (scanCnt == scanW'(`SCAN_DIV - 1)) begin
                scanCnt  <= '0;
                digitSel <= (digitSel == 2'd2) ? 2'd0 : digitSel + 1'b1;
            end else begin
                scanCnt <= scanCnt + 1'b1;
            end
        end
    end

endmodule

// File: source/bubbleLane.sv
`include "bubble_params.svh"

module bubbleLane #(
    parameter int LANE_ID = 0
) (
    input  logic                   MCLK,
    input  logic                   rstN,
    input  bubblePkg::bufWrite_t   bufWr,
    input  logic                   bitOutEn,
    input  bubblePkg::accType_t    accType,
    output logic                   dout
);
    import bubblePkg::*;

    localparam int laneW = $clog2(`LANE_COUNT);
    localparam int addrW = $clog2(`PAGE_BITS);

    logic [`PAGE_BITS-1:0]  pageBuf;
    logic [addrW-1:0]       rdPtr;
    logic                   laneHit;

    assign laneHit = bufWr.wrEn && (bufWr.lane == laneW'(LANE_ID));

    always_ff @(posedge MCLK) begin
        if (laneHit) begin
            pageBuf[bufWr.addr] <= bufWr.data;
        end
    end

    // Pointer parked at 0 outside shift, so each page starts at bit 0
    always_ff @(posedge MCLK) begin
        if (!rstN) begin
            rdPtr <= '0;
            dout  <= 1'b0;
        end else if (accType == ACC_SHIFT) begin
            if (bitOutEn) begin
                dout  <= pageBuf[rdPtr];
                rdPtr <= rdPtr + 1'b1;
            end
        end else begin
            rdPtr <= '0;
            dout  <= 1'b0;
        end
    end

    assert property (@(posedge MCLK) disable iff (!rstN)
        laneHit |-> accType != ACC_SHIFT);

endmodule

// File: source/spiLoader.sv
`include "bubble_params.svh"

module spiLoader (
    input  logic                   MCLK,
    input  logic                   rstN,
    input  bubblePkg::loadReq_t    loadReq,
    output logic                   loadDone,
    output bubblePkg::bufWrite_t   bufWr,
    output logic                   nCs,
    output logic                   mosi,
    input  logic                   miso,
    output logic                   romClk
);
    localparam int pageBytes = `LANE_COUNT * `PAGE_BITS / 8;
    // Read command plus 24-bit address
    localparam int headBits = 32;
    localparam int totalBits = headBits + `LANE_COUNT * `PAGE_BITS;
    localparam int bitW = $clog2(totalBits);
    localparam int halfW = $clog2(`SPI_DIV);
    localparam int laneW = $clog2(`LANE_COUNT);
    localparam int addrW = $clog2(`PAGE_BITS);

    logic [23:0]       flashAddr;
    logic [31:0]       txShift;
    logic [bitW-1:0]   bitIdx;
    logic [bitW-1:0]   dataIdx;
    logic [halfW-1:0]  halfCnt;
    logic              halfEnd;

    assign flashAddr = 24'(loadReq.imgNum) * 24'(`PAGE_COUNT * pageBytes)
                     + 24'(loadReq.page) * 24'(pageBytes);

    assign halfEnd = (halfCnt == halfW'(`SPI_DIV - 1));
    assign dataIdx = bitIdx - bitW'(headBits);

    // Mode 0, so MOSI is already valid before each rising edge
    assign mosi = txShift[31];

    always_ff @(posedge MCLK) begin
        if (!rstN) begin
            nCs      <= 1'b1;
            romClk   <= 1'b0;
            loadDone <= 1'b0;
            txShift  <= '0;
            bitIdx   <= '0;
            halfCnt  <= '0;
            bufWr    <= '0;
        end else begin
            loadDone   <= 1'b0;
            bufWr.wrEn <= 1'b0;
            if (nCs) begin
                if (loadReq.start) begin
                    nCs     <= 1'b0;
                    txShift <= {8'h03, flashAddr};
                    bitIdx  <= '0;
                    halfCnt <= '0;
                end
            end else if (halfEnd) begin
                halfCnt <= '0;
                if (!romClk) begin
                    romClk <= 1'b1;
                    // Sample on the rising edge once past the header
                    if (bitIdx >= bitW'(headBits)) begin
                        bufWr.wrEn <= 1'b1;
                        bufWr.lane <= laneW'(dataIdx % `LANE_COUNT);
                        bufWr.addr <= addrW'(dataIdx / `LANE_COUNT);
                        bufWr.data <= miso;
                    end
                end else begin
                    romClk <= 1'b0;
                    if (bitIdx == bitW'(totalBits - 1)) begin
                        nCs      <= 1'b1;
                        loadDone <= 1'b1;
                    end else begin
                        bitIdx  <= bitIdx + 1'b1;
                        txShift <= {txShift[30:0], 1'b0};
                    end
                end
            end else begin
                halfCnt <= halfCnt + 1'b1;
            end
        end
    end

    // One chip-select frame per request
    assert property (@(posedge MCLK) disable iff (!rstN)
        $fell(nCs) |-> $past(loadReq.start));
    assert property (@(posedge MCLK) disable iff (!rstN)
        $rose(nCs) |-> loadDone);

    // Requester must wait for the current page
    assert property (@(posedge MCLK) disable iff (!rstN)
        loadReq.start |-> nCs);

endmodule

// File: source/timingGenerator.sv
`include "bubble_params.svh"

module timingGenerator (
    input  logic                  MCLK,
    input  logic                  rstN,
    input  logic                  nBSEN,
    input  logic [`IMG_W-1:0]     imgNum,
    input  logic                  loadDone,
    output bubblePkg::accType_t   accType,
    output bubblePkg::loadReq_t   loadReq,
    output logic                  bitOutEn,
    output logic [`PAGE_W-1:0]    currPage,
    output logic                  clkOut
);
    import bubblePkg::*;

    localparam int bitCntW = $clog2(`PAGE_BITS) + 1;
    localparam int divW = $clog2(`OUT_DIV);
    localparam int clkW = $clog2(`CLKOUT_DIV);
    localparam logic [`PAGE_W-1:0] lastPage = `PAGE_COUNT - 1;

    logic [2:0]          bsenSync;
    logic                bsenFall;
    logic [divW-1:0]     divCnt;
    logic [bitCntW-1:0]  bitCnt;
    logic [clkW-1:0]     clkCnt;
    logic                periodEnd;

    // Two synchronizer stages, the third flop only for edge detection
    always_ff @(posedge MCLK) begin
        if (!rstN) begin
            bsenSync <= 3'b111;
        end else begin
            bsenSync <= {bsenSync[1:0], nBSEN};
        end
    end

    assign bsenFall = bsenSync[2] & ~bsenSync[1];
    assign periodEnd = (divCnt == divW'(`OUT_DIV - 1));

    // First pulse right at shift entry, then one per OUT_DIV cycles
    assign bitOutEn = (accType == ACC_SHIFT) && (divCnt == '0)
                      && (bitCnt < bitCntW'(`PAGE_BITS));

    always_ff @(posedge MCLK) begin
        if (!rstN) begin
            accType  <= ACC_IDLE;
            loadReq  <= '0;
            currPage <= '0;
            divCnt   <= '0;
            bitCnt   <= '0;
        end else begin
            loadReq.start <= 1'b0;
            case (accType)
                ACC_IDLE: begin
                    // Only a fresh edge starts an access
                    if (bsenFall) begin
                        accType        <= ACC_LOAD;
                        loadReq.start  <= 1'b1;
                        loadReq.imgNum <= imgNum;
                        loadReq.page   <= currPage;
                    end
                end
                ACC_LOAD: begin
                    divCnt <= '0;
                    bitCnt <= '0;
                    if (loadDone) begin
                        accType <= ACC_SHIFT;
                    end
                end
                ACC_SHIFT: begin
                    divCnt <= periodEnd ? '0 : divCnt + 1'b1;
                    if (bitOutEn) begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                    // Last bit keeps its full period before going idle
                    if (periodEnd && bitCnt == bitCntW'(`PAGE_BITS)) begin
                        accType  <= ACC_IDLE;
                        currPage <= (currPage == lastPage) ? '0 : currPage + 1'b1;
                    end
                end
                default: accType <= ACC_IDLE;
            endcase
        end
    end

    // Cartridge clock
    always_ff @(posedge MCLK) begin
        if (!rstN) begin
            clkCnt <= '0;
            clkOut <= 1'b0;
        end else if (clkCnt == clkW'(`CLKOUT_DIV - 1)) begin
            clkCnt <= '0;
            clkOut <= ~clkOut;
        end else begin
            clkCnt <= clkCnt + 1'b1;
        end
    end

    assert property (@(posedge MCLK) disable iff (!rstN)
        bitOutEn |-> accType == ACC_SHIFT);

endmodule

// File: source/bubblePkg.sv
`include "bubble_params.svh"

package bubblePkg;

    // Access phase shared by all blocks
    typedef enum logic [1:0] {
        ACC_IDLE  = 2'd0,
        ACC_LOAD  = 2'd1,
        ACC_SHIFT = 2'd2
    } accType_t;

    // Page request from the timing generator to the loader
    typedef struct packed {
        logic                 start;
        logic [`IMG_W-1:0]    imgNum;
        logic [`PAGE_W-1:0]   page;
    } loadReq_t;

    // One received bit, broadcast to every lane
    typedef struct packed {
        logic                             wrEn;
        logic [$clog2(`LANE_COUNT)-1:0]   lane;
        logic [$clog2(`PAGE_BITS)-1:0]    addr;
        logic                             data;
    } bufWrite_t;

endpackage

// File: source/bubble_params.svh
`ifndef BUBBLE_PARAMS_SVH
`define BUBBLE_PARAMS_SVH

// Page geometry
// Bits per lane per page
`define PAGE_BITS 64
// Data lanes, one per dout pin
`define LANE_COUNT 2
// Pages in the rotating loop, power of two up to 4096
`define PAGE_COUNT 4

// Field widths
`define PAGE_W 12
`define IMG_W 3

// Clock dividers, all in MCLK cycles
// One output bit period
`define OUT_DIV 12
// Half period of the flash SPI clock
`define SPI_DIV 2
// Half period of the cartridge clock
`define CLKOUT_DIV 6
// Dwell time per display digit
`define SCAN_DIV 64

`endif
